/* mips_cpu.f */
+incdir+verif
src/mips_pkg.sv
src/ctrl_if.sv
src/controller.sv
src/alu.sv
src/reg_file.sv
src/datapath.sv
src/instr_mem.sv
src/data_mem.sv
src/mips_top.sv
verif/tb_mips.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with verilator, verdict from the log
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_mips -f mips_cpu.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vtb_mips > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$log"; then
    echo "simulation reported failure"
    exit 1
fi
exit 0

/* verif/mips_ref.svh */
// linear congruential generator, 32-bit state
function automatic word_t lcg_next(input word_t s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

// instruction level model, one pc per executed instruction
function automatic void run_ref(
    input  word_t prog [imem_depth],
    input  int    nsteps,
    output word_t pcs [$],
    output word_t st_addr [$],
    output word_t st_data [$]
);
    word_t regs [32];
    word_t dmem [dmem_depth];
    word_t pc;
    word_t nxt;
    word_t ins;
    word_t a;
    word_t b;
    word_t imm;
    word_t addr;

    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < dmem_depth; i++) begin
        dmem[i] = '0;
    end
    pcs     = {};
    st_addr = {};
    st_data = {};
    pc      = '0;
    for (int s = 0; s < nsteps; s++) begin
        ins  = prog[pc[7:2]];
        a    = regs[ins[25:21]];
        b    = regs[ins[20:16]];
        imm  = {{16{ins[15]}}, ins[15:0]};
        addr = a + imm;
        nxt  = pc + 32'd4;
        pcs.push_back(pc);
        case (ins[31:26])
            op_rtype: begin
                case (ins[5:0])
                    funct_add: regs[ins[15:11]] = a + b;
                    funct_sub: regs[ins[15:11]] = a - b;
                    funct_and: regs[ins[15:11]] = a & b;
                    funct_or:  regs[ins[15:11]] = a | b;
                    funct_slt: regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:   ;  // unknown funct writes nothing
                endcase
            end
            op_addi: regs[ins[20:16]] = addr;
            op_lw:   regs[ins[20:16]] = dmem[addr[7:2]];
            op_sw: begin
                dmem[addr[7:2]] = b;
                st_addr.push_back(addr);
                st_data.push_back(b);
            end
            op_beq: if (a == b) nxt = nxt + {imm[29:0], 2'b00};
            op_j:   nxt = {nxt[31:28], ins[25:0], 2'b00};
            default: ;
        endcase
        regs[0] = '0;  // $zero
        pc = nxt;
    end
endfunction

/* verif/tb_mips.sv */
`timescale 1ns/10ps

module tb_mips;
    import mips_pkg::*;

    localparam int clk_period = 20;
    localparam int spin_steps = 4;  // steps spent on the final jump-to-self
    localparam int max_cycles = 3 * (2 * imem_depth + spin_steps) + 100;

    logic               clk;
    logic               rst_n;
    logic               prog_we;
    logic [imem_aw-1:0] prog_addr;
    word_t              prog_data;
    word_t              pc;
    logic               mem_write;
    word_t              data_addr;
    word_t              write_data;

    word_t prog [imem_depth];
    int    prog_len;
    word_t seed;
    string test_name;
    word_t exp_pc [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    step_idx;
    int    store_idx;
    logic  checking;
    int    pc_errors;
    int    store_errors;
    int    other_errors;

    `include "mips_ref.svh"

    mips_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic word_t enc_r(input logic [5:0] funct, input int rd, input int rs,
                                    input int rt);
        return {op_rtype, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input int rs, input int rt,
                                    input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic word_t enc_j(input int target);
        return {op_j, 26'(target)};  // word index, upper pc bits are 0
    endfunction

    task automatic new_prog(input string name);
        test_name = name;
        prog_len  = 0;
        for (int i = 0; i < imem_depth; i++) begin
            prog[i] = '0;
        end
    endtask

    task automatic emit(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    // r-type into r6, then store r6
    task automatic alu_store(input logic [5:0] funct, input int rs, input int rt,
                             input int addr);
        emit(enc_r(funct, 6, rs, rt));
        emit(enc_i(op_sw, 0, 6, 16'(addr)));
    endtask

    task automatic build_alu_prog();
        logic [15:0] imm;
        new_prog("alu_ops");
        for (int k = 1; k <= 5; k++) begin
            seed = lcg_next(seed);
            imm  = seed[31:16];
            if (k >= 3) imm[15] = (k != 5);  // r3 and r4 negative, r5 positive
            emit(enc_i(op_addi, 0, k, imm));
        end
        alu_store(funct_add, 1, 2, 0);
        alu_store(funct_sub, 1, 2, 4);
        alu_store(funct_and, 1, 3, 8);
        alu_store(funct_or, 2, 4, 12);
        alu_store(funct_slt, 3, 4, 16);
        alu_store(funct_slt, 4, 3, 20);
        alu_store(funct_slt, 3, 5, 24);
        alu_store(funct_slt, 5, 3, 28);
        emit(enc_j(prog_len));
    endtask

    task automatic build_branch_prog();
        new_prog("mem_branch_jump");
        emit(enc_i(op_sw, 0, 0, 16'h003c));  // a store at pc 0 while reset is held
        emit(enc_i(op_addi, 0, 1, 16'h1234));
        emit(enc_i(op_sw, 0, 1, 16'h0020));
        emit(enc_i(op_lw, 0, 2, 16'h0020));  // read back into r2
        emit(enc_i(op_sw, 0, 2, 16'h0024));
        emit(enc_i(op_beq, 1, 2, 16'd1));    // taken, skips the next store
        emit(enc_i(op_sw, 0, 1, 16'h0028));
        emit(enc_i(op_addi, 0, 3, 16'hfffb));
        emit(enc_i(op_beq, 1, 3, 16'd1));    // not taken
        emit(enc_i(op_sw, 0, 3, 16'h002c));
        emit(enc_j(prog_len + 2));
        emit(enc_i(op_sw, 0, 3, 16'h0030));  // jumped over
        emit(enc_i(op_sw, 0, 1, 16'h0034));
        emit(enc_j(prog_len));
    endtask

    task automatic build_random_prog();
        int rs;
        int rt;
        int rd;
        new_prog("random");
        for (int k = 0; k < 40; k++) begin
            seed = lcg_next(seed);
            rs   = int'(seed[27:25]);
            rt   = int'(seed[24:22]);
            rd   = int'(seed[21:19]);  // r0 now and then
            case (seed[31:28])
                4'd5, 4'd6:          emit(enc_r(funct_add, rd, rs, rt));
                4'd7:                emit(enc_r(funct_sub, rd, rs, rt));
                4'd8:                emit(enc_r(funct_and, rd, rs, rt));
                4'd9:                emit(enc_r(funct_or, rd, rs, rt));
                4'd10:               emit(enc_r(funct_slt, rd, rs, rt));
                4'd11, 4'd12, 4'd13: emit(enc_i(op_sw, 0, rt, {8'd0, seed[7:2], 2'b00}));
                default:             emit(enc_i(op_addi, rs, rd, seed[18:3]));
            endcase
        end
        emit(enc_j(prog_len));
    endtask

    // reset lasts 16 cycles, or longer while a long program is still loading
    task automatic run_prog(input int nsteps);
        int load_cycles;
        run_ref(prog, nsteps, exp_pc, exp_addr, exp_data);
        load_cycles = (prog_len > 16) ? prog_len : 16;
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        for (int i = 0; i < load_cycles; i++) begin
            prog_we   = (i < prog_len);
            prog_addr = imem_aw'(i);
            prog_data = prog[i];
            @(posedge clk);
            #2;
        end
        prog_we   = 1'b0;
        step_idx  = 0;
        store_idx = 0;
        checking  = 1'b1;
        rst_n     = 1'b1;
        wait (step_idx == nsteps);
        checking = 1'b0;
        if (store_idx != exp_addr.size()) begin
            $display("%s: %0d stores seen but %0d expected", test_name, store_idx,
                     exp_addr.size());
            other_errors++;
        end
    endtask

    // sample mid-cycle, where the outputs of the executing instruction are settled
    always @(negedge clk) begin
        if (!rst_n) begin
            if (mem_write !== 1'b0 || pc !== 32'd0) begin
                $display("pc or mem_write not held at 0 during reset");
                other_errors++;
            end
        end else if (checking && step_idx < exp_pc.size()) begin
            if (pc !== exp_pc[step_idx]) begin
                $display("FAILED %s pc at step %0d: expected %h, actual %h", test_name,
                         step_idx, exp_pc[step_idx], pc);
                pc_errors++;
            end
            if (mem_write === 1'b1) begin
                if (store_idx >= exp_addr.size()) begin
                    $display("%s: store to %h at step %0d was not expected", test_name,
                             data_addr, step_idx);
                    other_errors++;
                end else if (data_addr !== exp_addr[store_idx] ||
                             write_data !== exp_data[store_idx]) begin
                    $display("FAILED %s store %0d: expected %h <= %h, actual %h <= %h",
                             test_name, store_idx, exp_addr[store_idx],
                             exp_data[store_idx], data_addr, write_data);
                    store_errors++;
                end
                store_idx++;
            end
            step_idx++;
        end
    end

    initial begin
        #(max_cycles * clk_period);
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        checking     = 1'b0;
        step_idx     = 0;
        store_idx    = 0;
        pc_errors    = 0;
        store_errors = 0;
        other_errors = 0;
        seed         = 32'd10;
        build_alu_prog();
        run_prog(prog_len + spin_steps);
        build_branch_prog();
        run_prog(prog_len + spin_steps);
        build_random_prog();
        run_prog(prog_len + spin_steps);
        $display("errors: pc %0d, store %0d, other %0d", pc_errors, store_errors,
                 other_errors);
        if (pc_errors + store_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* src/mips_top.sv */
`timescale 1ns/10ps

module mips_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         prog_we,
    input  logic [mips_pkg::imem_aw-1:0] prog_addr,
    input  mips_pkg::word_t              prog_data,
    output mips_pkg::word_t              pc,
    output logic                         mem_write,
    output mips_pkg::word_t              data_addr,
    output mips_pkg::word_t              write_data
);
    import mips_pkg::*;

    instr_t instr;
    word_t  read_data;

    ctrl_if u_ctrl_if ();

    controller u_controller (
        .instr (instr),
        .rst_n (rst_n),
        .ctrl  (u_ctrl_if.ctl)
    );

    datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (u_ctrl_if.dp),
        .instr_addr (pc),
        .instr      (instr),
        .data_addr  (data_addr),
        .write_data (write_data),
        .read_data  (read_data)
    );

    instr_mem u_instr_mem (
        .clk       (clk),
        .addr      (pc),
        .instr     (instr),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data)
    );

    data_mem u_data_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (u_ctrl_if.mem_write),
        .addr  (data_addr),
        .wd    (write_data),
        .rd    (read_data)
    );

    assign mem_write = u_ctrl_if.mem_write;

endmodule

/* src/data_mem.sv */
`timescale 1ns/10ps

module data_mem (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            we,
    input  mips_pkg::word_t addr,
    input  mips_pkg::word_t wd,
    output mips_pkg::word_t rd
);
    import mips_pkg::*;

    word_t mem [dmem_depth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < dmem_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr[dmem_aw+1:2]] <= wd;
        end
    end

    assign rd = mem[addr[dmem_aw+1:2]];

endmodule

/* src/instr_mem.sv */
`timescale 1ns/10ps

module instr_mem (
    input  logic                         clk,
    input  mips_pkg::word_t              addr,
    output mips_pkg::word_t              instr,
    input  logic                         prog_we,
    input  logic [mips_pkg::imem_aw-1:0] prog_addr,
    input  mips_pkg::word_t              prog_data
);
    import mips_pkg::*;

    // words never loaded stay 0, a harmless r-type
    word_t mem [imem_depth] = '{default: '0};

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    assign instr = mem[addr[imem_aw+1:2]];  // word addressed

endmodule

/* src/datapath.sv */
`timescale 1ns/10ps

module datapath (
    input  logic             clk,
    input  logic             rst_n,
    ctrl_if.dp               ctrl,
    output mips_pkg::word_t  instr_addr,
    input  mips_pkg::instr_t instr,
    output mips_pkg::word_t  data_addr,
    output mips_pkg::word_t  write_data,
    input  mips_pkg::word_t  read_data
);
    import mips_pkg::*;

    word_t      pc;
    word_t      pc_next;
    word_t      pc_plus4;
    word_t      branch_target;
    word_t      jump_target;
    word_t      imm_ext;
    word_t      rd1;
    word_t      rd2;
    word_t      src_b;
    word_t      alu_result;
    word_t      result;
    logic [4:0] write_reg;
    logic       zero;
    logic       pc_src;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_plus4 = pc + 32'd4;
    assign imm_ext  = {{16{instr.i.imm16[15]}}, instr.i.imm16};

    // branch offset counts words from pc + 4
    assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], instr.j.target26, 2'b00};

    assign pc_src = ctrl.branch & zero;

    always_comb begin
        pc_next = pc_plus4;
        if (pc_src) begin
            pc_next = branch_target;
        end
        if (ctrl.jump) begin
            pc_next = jump_target;
        end
    end

    assign write_reg = ctrl.reg_dst ? instr.r.rd : instr.r.rt;

    reg_file u_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (ctrl.reg_write),
        .ra1   (instr.r.rs),
        .ra2   (instr.r.rt),
        .wa    (write_reg),
        .wd    (result),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    assign src_b = ctrl.alu_src ? imm_ext : rd2;

    alu u_alu (
        .a           (rd1),
        .b           (src_b),
        .alu_control (ctrl.alu_control),
        .result      (alu_result),
        .zero        (zero)
    );

    // write-back select
    assign result = ctrl.mem_to_reg ? read_data : alu_result;

    assign instr_addr = pc;
    assign data_addr  = alu_result;
    assign write_data = rd2;  // sw stores rt

endmodule

/* src/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            we,
    input  logic [4:0]      ra1,
    input  logic [4:0]      ra2,
    input  logic [4:0]      wa,
    input  mips_pkg::word_t wd,
    output mips_pkg::word_t rd1,
    output mips_pkg::word_t rd2
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != 5'd0)) begin  // $zero is never written
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

/* src/alu.sv */
`timescale 1ns/10ps

module alu (
    input  mips_pkg::word_t     a,
    input  mips_pkg::word_t     b,
    input  mips_pkg::alu_ctrl_t alu_control,
    output mips_pkg::word_t     result,
    output logic                zero
);
    import mips_pkg::*;

    word_t b_mux;
    word_t sum;
    word_t a_and_b;
    word_t a_or_b;
    word_t slt_word;
    word_t lvl_or_sum;
    word_t lvl_and_slt;

    // subtract is a + ~b + 1
    assign b_mux = alu_control[2] ? ~b : b;
    assign sum   = a + b_mux + {31'd0, alu_control[2]};

    assign a_and_b = a & b_mux;
    assign a_or_b  = a | b_mux;

    // sign of the difference moved to bit 0
    assign slt_word = {31'd0, sum[31]};

    assign lvl_or_sum  = alu_control[1] ? sum : a_or_b;
    assign lvl_and_slt = alu_control[1] ? slt_word : a_and_b;
    assign result      = alu_control[0] ? lvl_and_slt : lvl_or_sum;

    assign zero = (a == b);  // used by beq

endmodule

/* src/controller.sv */
`timescale 1ns/10ps

module controller (
    input  mips_pkg::instr_t instr,
    input  logic             rst_n,
    ctrl_if.ctl              ctrl
);
    import mips_pkg::*;

    logic [1:0] alu_op;
    logic       reg_write_dec;
    logic       mem_write_dec;
    logic       funct_valid;

    // main decoder
    always_comb begin
        reg_write_dec   = 1'b0;
        mem_write_dec   = 1'b0;
        ctrl.reg_dst    = 1'b0;
        ctrl.alu_src    = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.jump       = 1'b0;
        alu_op          = aluop_add;
        case (instr.r.opcode)
            op_rtype: begin
                reg_write_dec = 1'b1;
                ctrl.reg_dst  = 1'b1;
                alu_op        = aluop_funct;
            end
            op_lw: begin
                reg_write_dec   = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            op_sw: begin
                mem_write_dec = 1'b1;
                ctrl.alu_src  = 1'b1;
            end
            op_beq: begin
                ctrl.branch = 1'b1;
                alu_op      = aluop_sub;
            end
            op_addi: begin
                reg_write_dec = 1'b1;
                ctrl.alu_src  = 1'b1;
            end
            op_j:    ctrl.jump = 1'b1;
            default: ;  // unknown opcode, nothing is written
        endcase
    end

    // alu decoder
    always_comb begin
        funct_valid = 1'b1;
        case (alu_op)
            aluop_add: ctrl.alu_control = alu_add;
            aluop_sub: ctrl.alu_control = alu_sub;
            default: begin
                case (instr.r.funct)
                    funct_add: ctrl.alu_control = alu_add;
                    funct_sub: ctrl.alu_control = alu_sub;
                    funct_and: ctrl.alu_control = alu_and;
                    funct_or:  ctrl.alu_control = alu_or;
                    funct_slt: ctrl.alu_control = alu_slt;
                    default: begin
                        ctrl.alu_control = alu_add;
                        funct_valid      = 1'b0;  // e.g. the all-zero word
                    end
                endcase
            end
        endcase
    end

    // no state changes while reset is held
    assign ctrl.reg_write = rst_n & funct_valid & reg_write_dec;
    assign ctrl.mem_write = rst_n & mem_write_dec;

endmodule

/* src/ctrl_if.sv */
`timescale 1ns/10ps

interface ctrl_if;
    import mips_pkg::*;

    logic      reg_write;
    logic      reg_dst;     // 1 selects rd as destination
    logic      alu_src;     // 1 selects the immediate
    logic      mem_to_reg;
    logic      branch;
    logic      jump;
    logic      mem_write;
    alu_ctrl_t alu_control;

    modport ctl (
        output reg_write, reg_dst, alu_src, mem_to_reg,
        output branch, jump, mem_write, alu_control
    );

    modport dp (
        input reg_write, reg_dst, alu_src, mem_to_reg,
        input branch, jump, mem_write, alu_control
    );

endinterface

/* src/mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;

    // memory sizes in words
    localparam int imem_depth = 64;
    localparam int dmem_depth = 64;
    localparam int imem_aw    = $clog2(imem_depth);
    localparam int dmem_aw    = $clog2(dmem_depth);

    // major opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // r-type function field
    localparam logic [5:0] funct_add = 6'h20;
    localparam logic [5:0] funct_sub = 6'h22;
    localparam logic [5:0] funct_and = 6'h24;
    localparam logic [5:0] funct_or  = 6'h25;
    localparam logic [5:0] funct_slt = 6'h2a;

    // bit 2 inverts b and sets carry in, bit 1 adder side, bit 0 second mux level
    typedef logic [2:0] alu_ctrl_t;

    localparam alu_ctrl_t alu_or  = 3'b000;
    localparam alu_ctrl_t alu_and = 3'b001;
    localparam alu_ctrl_t alu_add = 3'b010;
    localparam alu_ctrl_t alu_sub = 3'b110;
    localparam alu_ctrl_t alu_slt = 3'b111;

    // operation class from the main decoder
    localparam logic [1:0] aluop_add   = 2'b00;
    localparam logic [1:0] aluop_sub   = 2'b01;
    localparam logic [1:0] aluop_funct = 2'b10;

    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target26;
        } j;
    } instr_t;

endpackage
